//--- flist.f
hw/arp_pkg.sv
hw/arp_rx.sv
hw/arp_tx.sv
hw/arp_table.sv
hw/arp_core.sv
verif/arp_core_assert.sv
verif/arp_core_tb.sv

//--- Makefile
# Verilator build and run of the ARP block testbench

VERILATOR ?= verilator
TOP       ?= arp_core_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR JOBS VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/arp_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module arp_core_tb;

  import arp_pkg::*;

  localparam logic [47:0] OUR_MAC    = 48'h02_00_5e_10_20_30;
  localparam logic [31:0] OUR_IP     = 32'hc0a8_0105;
  localparam int          WAIT_LIMIT = ARP_TIMEOUT + 2 * ARP_LEN;

  logic        clk = 1'b0;
  logic        arst_n;
  logic        rx_valid;
  logic [7:0]  rx_data;
  logic        rx_last;
  logic        tx_valid;
  logic [7:0]  tx_data;
  logic        tx_last;
  logic        tbl_req;
  logic [31:0] tbl_ipv4;
  logic        tbl_val;
  logic [47:0] tbl_mac;
  logic        tbl_err;
  logic        tbl_busy;
  logic [31:0] lfsr = 32'h9071fa01;

  arp_core u_arp_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .mac_addr  (OUR_MAC),
    .ipv4_addr (OUR_IP),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_last   (rx_last),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_last   (tx_last),
    .tbl_req   (tbl_req),
    .tbl_ipv4  (tbl_ipv4),
    .tbl_val   (tbl_val),
    .tbl_mac   (tbl_mac),
    .tbl_err   (tbl_err),
    .tbl_busy  (tbl_busy)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (u_arp_core.u_assert.fail_count != 0) abort_run("a protocol assertion failed");
  end

  // --------------------------------------------------------------------------
  // random source, helpers and checks
  // --------------------------------------------------------------------------
  function automatic logic lfsr_bit(); // x^32 + x^22 + x^2 + x + 1
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [47:0] rand_bits(input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[46:0], lfsr_bit()};
    return v;
  endfunction

  // standard ARP field order with byte 0 as the msb
  function automatic logic [ARP_LEN*8-1:0] build_frame(input arp_oper_e oper,
      input logic [47:0] sha, input logic [31:0] spa,
      input logic [47:0] tha, input logic [31:0] tpa);
    return {ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN, 16'(oper), sha, spa, tha, tpa};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
                          $time, name, got, exp));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic run_reset();
    arst_n <= 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    check_eq("tx_valid", 64'(tx_valid), 64'(0));
    check_eq("tx_last", 64'(tx_last), 64'(0));
    check_eq("tbl_val", 64'(tbl_val), 64'(0));
    check_eq("tbl_err", 64'(tbl_err), 64'(0));
    check_eq("tbl_busy", 64'(tbl_busy), 64'(0));
  endtask

  // rx_last goes with byte len-1 and bytes past the payload are zero
  task automatic send_frame(input logic [ARP_LEN*8-1:0] frame, input int len, input bit gaps);
    for (int i = 0; i < len; i++) begin
      if (gaps && (rand_bits(2) == 48'd0)) begin
        rx_valid <= 1'b0;
        rx_last  <= 1'b0;
        @(posedge clk);
      end
      rx_valid <= 1'b1;
      rx_last  <= (i == len - 1);
      if (i < ARP_LEN) rx_data <= frame[8*(ARP_LEN-1-i) +: 8];
      else rx_data <= 8'h00;
      @(posedge clk);
    end
    rx_valid <= 1'b0;
    rx_last  <= 1'b0;
  endtask

  task automatic wait_tx(output int cycles);
    cycles = 0;
    @(posedge clk);
    while (!tx_valid) begin
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("timeout waiting for a frame on tx");
      @(posedge clk);
    end
  endtask

  task automatic expect_frame(input arp_oper_e oper, input logic [47:0] tha,
                              input logic [31:0] tpa, output int lat);
    logic [ARP_LEN*8-1:0] exp;
    exp = build_frame(oper, OUR_MAC, OUR_IP, tha, tpa);
    wait_tx(lat);
    for (int i = 0; i < ARP_LEN; i++) begin
      if (i > 0) @(posedge clk);
      check_eq($sformatf("tx_valid byte %0d", i), 64'(tx_valid), 64'(1));
      check_eq($sformatf("tx_data byte %0d", i), 64'(tx_data),
               64'(exp[8*(ARP_LEN-1-i) +: 8]));
      check_eq($sformatf("tx_last byte %0d", i), 64'(tx_last), 64'(i == ARP_LEN - 1));
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(posedge clk);
      check_eq("tx_valid", 64'(tx_valid), 64'(0));
    end
  endtask

  task automatic start_lookup(input logic [31:0] ip);
    int n;
    n = 0;
    while (tbl_busy) begin
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for the table to go idle");
      @(posedge clk);
    end
    tbl_req  <= 1'b1;
    tbl_ipv4 <= ip;
    @(posedge clk);
    tbl_req <= 1'b0;
  endtask

  task automatic wait_answer(input int limit, output logic val, output logic err);
    int n;
    n = 0;
    @(posedge clk);
    while (!tbl_val && !tbl_err) begin
      n++;
      if (n > limit) abort_run("timeout waiting for tbl_val or tbl_err");
      @(posedge clk);
    end
    val = tbl_val;
    err = tbl_err;
  endtask

  task automatic lookup_hit(input logic [31:0] ip, input logic [47:0] mac);
    start_lookup(ip);
    @(posedge clk); // a hit answers the cycle after the request
    check_eq("tbl_val", 64'(tbl_val), 64'(1));
    check_eq("tbl_err", 64'(tbl_err), 64'(0));
    check_eq("tbl_mac", 64'(tbl_mac), 64'(mac));
  endtask

  // miss -> request on tx -> reply from the target -> answer
  task automatic resolve_miss(input logic [31:0] ip, input logic [47:0] mac);
    int   lat;
    logic val;
    logic err;
    start_lookup(ip);
    expect_frame(ARP_OP_REQUEST, 48'h0, ip, lat);
    check_eq("tbl_busy", 64'(tbl_busy), 64'(1));
    send_frame(build_frame(ARP_OP_REPLY, mac, ip, OUR_MAC, OUR_IP), ARP_LEN, 1'b0);
    wait_answer(8, val, err);
    check_eq("tbl_val", 64'(val), 64'(1));
    check_eq("tbl_err", 64'(err), 64'(0));
    check_eq("tbl_mac", 64'(tbl_mac), 64'(mac));
    check_eq("tbl_busy", 64'(tbl_busy), 64'(0));
  endtask

  task automatic learn_sender(input logic [31:0] ip, input logic [47:0] mac);
    send_frame(build_frame(ARP_OP_REPLY, mac, ip, OUR_MAC, OUR_IP), ARP_LEN, 1'b1);
    idle(2);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic reply_to_request();
    logic [47:0] mac;
    logic [31:0] ip;
    int          lat;
    mac = rand_bits(48);
    ip  = 32'(rand_bits(32));
    send_frame(build_frame(ARP_OP_REQUEST, mac, ip, 48'h0, OUR_IP), ARP_LEN, 1'b1);
    expect_frame(ARP_OP_REPLY, mac, ip, lat);
    check_eq("reply latency", 64'(lat), 64'(3));
    idle(2);
  endtask

  task automatic ignore_foreign_request();
    logic [47:0] mac;
    logic [31:0] ip;
    mac = rand_bits(48);
    ip  = 32'(rand_bits(32));
    send_frame(build_frame(ARP_OP_REQUEST, mac, ip, 48'h0, OUR_IP ^ 32'h0000_0100),
               ARP_LEN, 1'b1);
    expect_quiet(16);
    lookup_hit(ip, mac);
  endtask

  task automatic drop_malformed();
    logic [ARP_LEN*8-1:0] frame;
    logic [ARP_LEN*8-1:0] bad;
    logic [47:0]          mac;
    logic [31:0]          ip;
    mac   = rand_bits(48);
    ip    = 32'(rand_bits(32));
    frame = build_frame(ARP_OP_REQUEST, mac, ip, 48'h0, OUR_IP);
    bad   = frame;
    bad[8*(ARP_LEN-4) +: 8] = 8'h06; // ptype 0x0806
    send_frame(bad, ARP_LEN, 1'b1);
    expect_quiet(16);
    send_frame(frame, ARP_LEN - 1, 1'b1);
    expect_quiet(16);
    send_frame(frame, ARP_LEN + 1, 1'b1);
    expect_quiet(16);
    resolve_miss(ip, mac);
  endtask

  task automatic resolve_on_reply();
    logic [47:0] mac;
    logic [31:0] ip;
    mac = rand_bits(48);
    ip  = 32'(rand_bits(32));
    resolve_miss(ip, mac);
    idle(2);
    lookup_hit(ip, mac);
  endtask

  task automatic give_up_after_retries();
    logic [31:0] ip;
    int          lat;
    logic        val;
    logic        err;
    ip = 32'(rand_bits(32));
    start_lookup(ip);
    for (int r = 0; r < ARP_RETRIES; r++) expect_frame(ARP_OP_REQUEST, 48'h0, ip, lat);
    check_eq("tbl_busy", 64'(tbl_busy), 64'(1));
    wait_answer(ARP_TIMEOUT + 8, val, err);
    check_eq("tbl_err", 64'(err), 64'(1));
    check_eq("tbl_val", 64'(val), 64'(0));
    check_eq("tbl_busy", 64'(tbl_busy), 64'(0));
    expect_quiet(ARP_TIMEOUT + ARP_LEN); // no extra request
  endtask

  task automatic evict_round_robin();
    logic [31:0] ips  [TABLE_SIZE + 2];
    logic [47:0] macs [TABLE_SIZE + 2];
    run_reset(); // empty table with slot 0 next
    for (int i = 0; i < TABLE_SIZE + 2; i++) begin
      ips[i]  = {8'h0a, 16'(rand_bits(16)), 8'(i)};
      macs[i] = rand_bits(48);
    end
    for (int i = 0; i <= TABLE_SIZE; i++) learn_sender(ips[i], macs[i]);
    macs[3] = rand_bits(48);
    learn_sender(ips[3], macs[3]);   // updated in place without taking a slot
    learn_sender(ips[TABLE_SIZE + 1], macs[TABLE_SIZE + 1]);
    for (int i = 2; i < TABLE_SIZE + 2; i++) lookup_hit(ips[i], macs[i]);
    resolve_miss(ips[0], macs[0]);
    resolve_miss(ips[1], macs[1]);
  endtask

  initial begin
    arst_n   <= 1'b0;
    rx_valid <= 1'b0;
    rx_data  <= 8'h00;
    rx_last  <= 1'b0;
    tbl_req  <= 1'b0;
    tbl_ipv4 <= 32'h0;
    run_reset();
    reply_to_request();
    ignore_foreign_request();
    drop_malformed();
    resolve_on_reply();
    give_up_after_retries();
    evict_round_robin();
    idle(4);
    if (u_arp_core.u_assert.fail_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("protocol assertions failed");
      $display("Errors found");
      $fatal(1, "simulation stopped");
    end
  end

endmodule : arp_core_tb

`default_nettype wire

//--- verif/arp_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module arp_core_assert (
  input logic clk,
  input logic arst_n,
  input logic tx_valid,
  input logic tx_last,
  input logic tbl_req,
  input logic tbl_val,
  input logic tbl_err,
  input logic tbl_busy
);

  import arp_pkg::*;

  int         fail_count = 0; // count of failed assertions
  logic [5:0] run_len;        // index of the current byte in a tx burst

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_len <= '0;
    end else if (tx_valid) begin
      run_len <= run_len + 1'b1;
    end else begin
      run_len <= '0;
    end
  end

  a_last_valid: assert property (@(posedge clk) disable iff (!arst_n)
    tx_last |-> tx_valid)
    else begin
      fail_count++;
      $error("tx_last seen without tx_valid");
    end

  // last byte exactly at index 27 and no longer burst
  a_burst_len: assert property (@(posedge clk) disable iff (!arst_n)
    tx_valid |-> (run_len < 6'(ARP_LEN)) && (tx_last == (run_len == 6'(ARP_LEN - 1))))
    else begin
      fail_count++;
      $error("tx burst length or tx_last position wrong");
    end

  a_burst_end: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(tx_valid) |-> $past(tx_last))
    else begin
      fail_count++;
      $error("tx burst ended before its last byte");
    end

  a_answer_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    !(tbl_val && tbl_err))
    else begin
      fail_count++;
      $error("tbl_val and tbl_err high together");
    end

  a_req_idle: assert property (@(posedge clk) disable iff (!arst_n)
    tbl_req |-> !tbl_busy)
    else begin
      fail_count++;
      $error("tbl_req sampled while tbl_busy");
    end

endmodule : arp_core_assert

bind arp_core arp_core_assert u_assert (
  .clk      (clk),
  .arst_n   (arst_n),
  .tx_valid (tx_valid),
  .tx_last  (tx_last),
  .tbl_req  (tbl_req),
  .tbl_val  (tbl_val),
  .tbl_err  (tbl_err),
  .tbl_busy (tbl_busy)
);

`default_nettype wire

//--- hw/arp_core.sv
`timescale 1ns/1ps
`default_nettype none

module arp_core (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [47:0] mac_addr,
  input  logic [31:0] ipv4_addr,
  input  logic        rx_valid,
  input  logic [7:0]  rx_data,
  input  logic        rx_last,
  output logic        tx_valid,
  output logic [7:0]  tx_data,
  output logic        tx_last,
  input  logic        tbl_req,
  input  logic [31:0] tbl_ipv4,
  output logic        tbl_val,
  output logic [47:0] tbl_mac,
  output logic        tbl_err,
  output logic        tbl_busy
);

  import arp_pkg::*;

  logic        rx_done;
  logic        send_reply;
  logic [47:0] rx_sha;
  logic [31:0] rx_spa;
  arp_oper_e   rx_oper;

  logic        send_req;
  logic [31:0] req_tpa;

  logic        send_tx;
  logic        tx_busy;
  arp_oper_e   tx_oper;
  logic [47:0] tx_tha;
  logic [31:0] tx_tpa;

  logic        rep_pend;
  logic        req_pend;
  logic [47:0] rep_tha;
  logic [31:0] rep_tpa;
  logic [31:0] req_tpa_q;
  logic        issue;
  logic        req_stale;

  arp_rx u_rx (
    .clk        (clk),
    .arst_n     (arst_n),
    .ipv4_addr  (ipv4_addr),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .rx_last    (rx_last),
    .rx_done    (rx_done),
    .send_reply (send_reply),
    .rx_sha     (rx_sha),
    .rx_spa     (rx_spa),
    .rx_oper    (rx_oper)
  );

  arp_tx u_tx (
    .clk       (clk),
    .arst_n    (arst_n),
    .mac_addr  (mac_addr),
    .ipv4_addr (ipv4_addr),
    .send_tx   (send_tx),
    .tx_oper   (tx_oper),
    .tx_tha    (tx_tha),
    .tx_tpa    (tx_tpa),
    .tx_busy   (tx_busy),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .tx_last   (tx_last)
  );

  // every accepted frame teaches the table its sender pair
  arp_table u_table (
    .clk       (clk),
    .arst_n    (arst_n),
    .learn     (rx_done),
    .learn_ip  (rx_spa),
    .learn_mac (rx_sha),
    .tbl_req   (tbl_req),
    .tbl_ipv4  (tbl_ipv4),
    .tbl_val   (tbl_val),
    .tbl_mac   (tbl_mac),
    .tbl_err   (tbl_err),
    .tbl_busy  (tbl_busy),
    .send_req  (send_req),
    .req_tpa   (req_tpa)
  );

  // --------------------------------------------------------------------------
  // reply / request chooser, replies first
  // --------------------------------------------------------------------------
  assign issue     = (rep_pend || req_pend) && !tx_busy && !send_tx;
  assign req_stale = rx_done && (rx_oper == ARP_OP_REPLY) && (rx_spa == req_tpa_q);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rep_pend <= 1'b0;
      req_pend <= 1'b0;
      send_tx  <= 1'b0;
    end else begin
      send_tx <= issue;
      if (issue) begin
        if (rep_pend) rep_pend <= 1'b0;
        else          req_pend <= 1'b0;
      end
      if (req_stale) req_pend <= 1'b0;   // answer already here, skip the request
      if (send_reply) rep_pend <= 1'b1;  // newer reply overwrites
      if (send_req)   req_pend <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (send_reply) begin
      rep_tha <= rx_sha;
      rep_tpa <= rx_spa;
    end
    if (send_req) req_tpa_q <= req_tpa;
    if (issue) begin
      if (rep_pend) begin
        tx_oper <= ARP_OP_REPLY;
        tx_tha  <= rep_tha;
        tx_tpa  <= rep_tpa;
      end else begin
        tx_oper <= ARP_OP_REQUEST;
        tx_tha  <= '0; // unknown target mac
        tx_tpa  <= req_tpa_q;
      end
    end
  end

endmodule : arp_core

`default_nettype wire

//--- hw/arp_table.sv
`timescale 1ns/1ps
`default_nettype none

module arp_table (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        learn,
  input  logic [31:0] learn_ip,
  input  logic [47:0] learn_mac,
  input  logic        tbl_req,
  input  logic [31:0] tbl_ipv4,
  output logic        tbl_val,
  output logic [47:0] tbl_mac,
  output logic        tbl_err,
  output logic        tbl_busy,
  output logic        send_req,
  output logic [31:0] req_tpa
);

  import arp_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REQUEST,
    ST_WAIT
  } table_state_e;

  table_state_e           state;
  logic [TABLE_SIZE-1:0]  ent_val;
  logic [31:0]            ent_ip  [TABLE_SIZE];
  logic [47:0]            ent_mac [TABLE_SIZE];
  logic [TABLE_IDX_W-1:0] wr_ptr;   // round-robin victim
  logic [31:0]            ip_q;     // address being resolved
  logic [TIMER_W-1:0]     timer;
  logic [RETRY_W-1:0]     tries;
  logic [31:0]            lk_ip;
  logic                   lk_hit;
  logic [TABLE_IDX_W-1:0] lk_idx;
  logic                   ln_hit;
  logic [TABLE_IDX_W-1:0] ln_idx;
  logic                   timeout;
  logic                   ln_match; // learned pair answers the pending miss

  // parallel compare against all valid entries, lowest index wins
  function automatic logic [TABLE_IDX_W:0] find_entry(input logic [31:0] ip);
    logic [TABLE_IDX_W:0] res;
    res = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (ent_val[i] && (ent_ip[i] == ip)) res = {1'b1, TABLE_IDX_W'(i)};
    end
    return res;
  endfunction

  assign lk_ip              = (state == ST_IDLE) ? tbl_ipv4 : ip_q;
  assign {lk_hit, lk_idx}   = find_entry(lk_ip);
  assign {ln_hit, ln_idx}   = find_entry(learn_ip);
  assign ln_match           = learn && (learn_ip == ip_q);
  assign timeout            = timer == TIMER_W'(ARP_TIMEOUT - 1);

  // --------------------------------------------------------------------------
  // learning, update in place or replace the next slot
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ent_val <= '0;
      wr_ptr  <= '0;
    end else if (learn && !ln_hit) begin
      ent_val[wr_ptr] <= 1'b1;
      wr_ptr <= (wr_ptr == TABLE_IDX_W'(TABLE_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (learn) begin
      if (ln_hit) begin
        ent_mac[ln_idx] <= learn_mac;
      end else begin
        ent_ip[wr_ptr]  <= learn_ip;
        ent_mac[wr_ptr] <= learn_mac;
      end
    end
  end

  // --------------------------------------------------------------------------
  // lookup and resolve FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      tbl_val  <= 1'b0;
      tbl_err  <= 1'b0;
      send_req <= 1'b0;
      timer    <= '0;
      tries    <= '0;
    end else begin
      tbl_val  <= 1'b0;
      tbl_err  <= 1'b0;
      send_req <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (tbl_req) begin
            if (lk_hit) begin
              tbl_val <= 1'b1;
            end else begin
              send_req <= 1'b1; // first request right away
              tries    <= RETRY_W'(1);
              timer    <= '0;
              state    <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          timer <= timer + 1'b1;
          if (ln_match) begin
            state <= ST_LOOKUP;
          end else if (timeout) begin
            if (tries == RETRY_W'(ARP_RETRIES)) begin
              tbl_err <= 1'b1;
              state   <= ST_IDLE;
            end else begin
              state <= ST_REQUEST;
            end
          end
        end
        ST_REQUEST: begin
          if (ln_match) begin
            state <= ST_LOOKUP;
          end else begin
            send_req <= 1'b1;
            tries    <= tries + 1'b1;
            timer    <= '0;
            state    <= ST_WAIT;
          end
        end
        ST_LOOKUP: begin
          // entry written last cycle, read it back
          if (lk_hit) begin
            tbl_val <= 1'b1;
            state   <= ST_IDLE;
          end else begin
            state <= ST_WAIT;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_IDLE) && tbl_req) ip_q <= tbl_ipv4;
    if (((state == ST_IDLE) && tbl_req) || (state == ST_LOOKUP)) begin
      if (lk_hit) tbl_mac <= ent_mac[lk_idx];
    end
  end

  assign tbl_busy = state != ST_IDLE;
  assign req_tpa  = ip_q;

endmodule : arp_table

`default_nettype wire

//--- hw/arp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module arp_tx (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [47:0]        mac_addr,
  input  logic [31:0]        ipv4_addr,
  input  logic               send_tx,
  input  arp_pkg::arp_oper_e tx_oper,
  input  logic [47:0]        tx_tha,
  input  logic [31:0]        tx_tpa,
  output logic               tx_busy,
  output logic               tx_valid,
  output logic [7:0]         tx_data,
  output logic               tx_last
);

  import arp_pkg::*;

  logic                 busy;
  logic [4:0]           cnt;
  logic                 cnt_end;
  arp_oper_e            oper_q;
  logic [47:0]          tha_q;
  logic [31:0]          tpa_q;
  logic [ARP_LEN*8-1:0] frame;

  // --------------------------------------------------------------------------
  // payload image in wire order, sender fields straight from the device
  // --------------------------------------------------------------------------
  assign frame = {
    ARP_HTYPE_ETH,
    ARP_PTYPE_IPV4,
    ARP_HLEN,
    ARP_PLEN,
    oper_q,
    mac_addr,
    ipv4_addr,
    tha_q,
    tpa_q
  };

  assign cnt_end = cnt == 5'(ARP_LEN - 1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!busy) begin
      cnt <= '0;
      if (send_tx) busy <= 1'b1;
    end else begin
      cnt <= cnt + 1'b1;
      if (cnt_end) busy <= 1'b0;
    end
  end

  // header latched once per frame, a send while busy is dropped
  always_ff @(posedge clk) begin
    if (send_tx && !busy) begin
      oper_q <= tx_oper;
      tha_q  <= tx_tha;
      tpa_q  <= tx_tpa;
    end
  end

  assign tx_busy  = busy;
  assign tx_valid = busy;
  assign tx_last  = busy && cnt_end;
  assign tx_data  = frame[8*(ARP_LEN-1-int'(cnt)) +: 8]; // byte 0 is the msb

endmodule : arp_tx

`default_nettype wire

//--- hw/arp_rx.sv
`timescale 1ns/1ps
`default_nettype none

module arp_rx (
  input  logic               clk,
  input  logic               arst_n,
  input  logic [31:0]        ipv4_addr,
  input  logic               rx_valid,
  input  logic [7:0]         rx_data,
  input  logic               rx_last,
  output logic               rx_done,
  output logic               send_reply,
  output logic [47:0]        rx_sha,
  output logic [31:0]        rx_spa,
  output arp_pkg::arp_oper_e rx_oper
);

  import arp_pkg::*;

  logic [4:0]  cnt;      // byte index, saturates at 31
  logic        err;
  logic        byte_bad;
  logic [15:0] oper_q;
  logic [47:0] sha_q;
  logic [31:0] spa_q;
  logic [23:0] tpa_q;    // tpa minus its last byte
  logic        oper_ok;
  logic        accept;
  logic        tgt_hit;

  // constant header bytes, anything past the payload is an error
  always_comb begin
    byte_bad = 1'b0;
    case (cnt)
      5'd0:    byte_bad = rx_data != ARP_HTYPE_ETH[15:8];
      5'd1:    byte_bad = rx_data != ARP_HTYPE_ETH[7:0];
      5'd2:    byte_bad = rx_data != ARP_PTYPE_IPV4[15:8];
      5'd3:    byte_bad = rx_data != ARP_PTYPE_IPV4[7:0];
      5'd4:    byte_bad = rx_data != ARP_HLEN;
      5'd5:    byte_bad = rx_data != ARP_PLEN;
      default: byte_bad = cnt >= 5'(ARP_LEN);
    endcase
  end

  assign oper_ok = (oper_q == ARP_OP_REQUEST) || (oper_q == ARP_OP_REPLY);
  assign tgt_hit = {tpa_q, rx_data} == ipv4_addr; // last byte still on the bus
  assign accept  = rx_valid && rx_last && !err && !byte_bad && oper_ok &&
                   (cnt == 5'(ARP_LEN - 1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt        <= '0;
      err        <= 1'b0;
      rx_done    <= 1'b0;
      send_reply <= 1'b0;
    end else begin
      rx_done    <= accept;
      send_reply <= accept && (oper_q == ARP_OP_REQUEST) && tgt_hit;
      if (rx_valid) begin
        if (rx_last) begin
          cnt <= '0;
          err <= 1'b0;
        end else begin
          if (cnt != 5'd31) cnt <= cnt + 1'b1;
          if (byte_bad) err <= 1'b1;
        end
      end
    end
  end

  // field capture, shifted in msb first
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      case (cnt) inside
        [5'd6:5'd7]:   oper_q <= {oper_q[7:0], rx_data};
        [5'd8:5'd13]:  sha_q  <= {sha_q[39:0], rx_data};
        [5'd14:5'd17]: spa_q  <= {spa_q[23:0], rx_data};
        [5'd24:5'd26]: tpa_q  <= {tpa_q[15:0], rx_data};
        default: ;
      endcase
    end
    if (accept) begin
      rx_sha  <= sha_q;
      rx_spa  <= spa_q;
      rx_oper <= arp_oper_e'(oper_q);
    end
  end

endmodule : arp_rx

`default_nettype wire

//--- hw/arp_pkg.sv
`default_nettype none

package arp_pkg;

  // --------------------------------------------------------------------------
  // ARP header constants (Ethernet / IPv4 only)
  // --------------------------------------------------------------------------
  localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  ARP_HLEN       = 8'd6;
  localparam logic [7:0]  ARP_PLEN       = 8'd4;

  localparam int ARP_LEN = 28; // payload bytes, no ethernet header

  typedef enum logic [15:0] {
    ARP_OP_REQUEST = 16'd1,
    ARP_OP_REPLY   = 16'd2
  } arp_oper_e;

  // --------------------------------------------------------------------------
  // table sizing and resolve timing
  // --------------------------------------------------------------------------
  localparam int TABLE_SIZE  = 8;
  localparam int ARP_TIMEOUT = 64; // cycles between retries
  localparam int ARP_RETRIES = 3;  // requests before giving up

  localparam int TABLE_IDX_W = $clog2(TABLE_SIZE);
  localparam int TIMER_W     = $clog2(ARP_TIMEOUT);
  localparam int RETRY_W     = $clog2(ARP_RETRIES + 1);

endpackage : arp_pkg

`default_nettype wire
